// File: src.f
+incdir+verilog
verilog/dcache_pkg.sv
verilog/dcache_mem_if.sv
verilog/dcache_ctrl_fsm.sv
verilog/dcache_tag_mem.sv
verilog/dcache_data_mem.sv
verilog/dcache_event_counter.sv
verilog/dcache_top.sv
tests/dcache_tb.sv

// File: tests/dcache_tb.sv
`timescale 1ns/1ps
`include "dcache_settings.svh"

module dcache_tb;

  localparam int NUM_REQS    = 400;
  localparam int CYCLE_LIMIT = NUM_REQS * 40;
  localparam int MEM_WORDS   = 1 << (`DCACHE_ADDR_W - 2);

  logic                       clk_i;
  logic                       reset_i;
  logic                       req_v_i;
  logic                       req_ready_o;
  logic                       req_we_i;
  logic [`DCACHE_ADDR_W-1:0]  req_addr_i;
  logic [`DCACHE_WORD_W-1:0]  req_wdata_i;
  logic                       resp_v_o;
  logic [`DCACHE_WORD_W-1:0]  resp_data_o;
  logic                       resp_ready_i;
  logic                       mem_req_v_o;
  logic                       mem_req_we_o;
  logic [`DCACHE_ADDR_W-1:0]  mem_req_addr_o;
  logic [`DCACHE_WORD_W-1:0]  mem_req_data_o;
  logic                       mem_req_ready_i;
  logic                       mem_resp_v_i;
  logic [`DCACHE_BLOCK_W-1:0] mem_resp_data_i;
  logic [`DCACHE_STAT_W-1:0]  stat_tag_read_count_o;
  logic [`DCACHE_STAT_W-1:0]  stat_data_read_count_o;
  logic [`DCACHE_STAT_W-1:0]  stat_hit_count_o;
  logic [`DCACHE_STAT_W-1:0]  stat_miss_count_o;
  logic [`DCACHE_STAT_W-1:0]  stat_wt_count_o;

  dcache_top dut (.*);

  // Next-level memory with one entry per word
  logic [`DCACHE_WORD_W-1:0] backing [MEM_WORDS];

  // Reference cache state
  logic [`DCACHE_TAG_W-1:0] model_tag [`DCACHE_SETS][2];
  logic [1:0]               model_valid [`DCACHE_SETS];
  logic                     model_lru [`DCACHE_SETS];

  integer                    seed;
  int                        cycle_count;
  int                        req_count;
  int                        store_count;
  int                        model_hits;
  int                        model_misses;
  int                        fill_seen;
  int                        wt_seen;
  int                        fill_delay;
  logic                      fill_pending;
  logic [13:0]               fill_base;
  logic                      cur_we;
  logic [`DCACHE_ADDR_W-1:0] cur_addr;
  logic [`DCACHE_WORD_W-1:0] cur_wdata;

  initial
  begin
    clk_i = 1'b0;
    forever
      #10 clk_i = ~clk_i;
  end

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    if (expected !== actual)
    begin
      $display("Mismatch in %s: expected %h, actual %h", name, expected, actual);
      $display("Simulation failed");
      $fatal(1, "value check failed");
    end
  endtask

  // Memory model accepts requests at random and answers fills after 0 to 5 cycles
  task automatic serve_memory;
    logic [`DCACHE_BLOCK_W-1:0] blk;
    mem_resp_v_i <= 1'b0;
    if (mem_req_v_o && mem_req_ready_i)
    begin
      if (mem_req_we_o)
      begin
        wt_seen++;
        check_value("write-through address", 32'(cur_addr), 32'(mem_req_addr_o));
        check_value("write-through data", cur_wdata, mem_req_data_o);
        backing[mem_req_addr_o[15:2]] = mem_req_data_o;
      end
      else
      begin
        fill_seen++;
        check_value("fill address", {16'b0, cur_addr[15:4], 4'b0}, 32'(mem_req_addr_o));
        fill_base    = mem_req_addr_o[15:2];
        fill_delay   = {$random(seed)} % 6;
        fill_pending = 1'b1;
      end
    end
    if (fill_pending)
    begin
      if (fill_delay == 0)
      begin
        for (int i = 0; i < 4; i++)
          blk[32*i +: 32] = backing[{fill_base[13:2], i[1:0]}];
        mem_resp_v_i    <= 1'b1;
        mem_resp_data_i <= blk;
        fill_pending = 1'b0;
      end
      else
        fill_delay--;
    end
    mem_req_ready_i <= (({$random(seed)} % 2) != 0);
  endtask

  task automatic tick;
    @(posedge clk_i);
    cycle_count++;
    if (cycle_count >= CYCLE_LIMIT)
    begin
      $display("Timeout: the cache stopped responding within %0d cycles", cycle_count);
      $display("Simulation failed");
      $fatal(1, "timeout");
    end
    serve_memory();
    resp_ready_i <= (({$random(seed)} % 4) != 0);
  endtask

  task automatic check_stats;
    // Counters lag their events by one cycle
    tick();
    check_value("tag read count", req_count, stat_tag_read_count_o);
    check_value("data read count", req_count, stat_data_read_count_o);
    check_value("hit count", model_hits, stat_hit_count_o);
    check_value("miss count", model_misses, stat_miss_count_o);
    check_value("write-through count", store_count, stat_wt_count_o);
  endtask

  task automatic run_request;
    int                        tag_v;
    int                        idx_v;
    int                        word_v;
    int                        accept_cycle;
    int                        first_resp;
    logic                      hit;
    logic                      hit_way;
    logic                      victim;
    logic                      seen;
    logic                      done;
    logic [3:0]                idx;
    logic [`DCACHE_WORD_W-1:0] held;
    // 3 tags by 4 sets by 4 words
    tag_v     = 64 + 37 * ({$random(seed)} % 3);
    idx_v     = 5 * ({$random(seed)} % 4);
    word_v    = {$random(seed)} % 4;
    cur_we    = (({$random(seed)} % 8) < 3);
    cur_addr  = {tag_v[7:0], idx_v[3:0], word_v[1:0], 2'b00};
    cur_wdata = $random(seed);
    idx       = cur_addr[7:4];
    hit       = 1'b0;
    hit_way   = 1'b0;
    for (int w = 0; w < 2; w++)
    begin
      if (model_valid[idx][w] && model_tag[idx][w] == cur_addr[15:8])
      begin
        hit     = 1'b1;
        hit_way = w[0];
      end
    end
    fill_seen = 0;
    wt_seen   = 0;
    req_v_i     <= 1'b1;
    req_we_i    <= cur_we;
    req_addr_i  <= cur_addr;
    req_wdata_i <= cur_wdata;
    done = 1'b0;
    while (!done)
    begin
      tick();
      done = req_v_i && req_ready_o;
    end
    accept_cycle = cycle_count;
    req_v_i <= 1'b0;
    seen = 1'b0;
    done = 1'b0;
    while (!done)
    begin
      tick();
      check_value("ready low while busy", 0, 32'(req_ready_o));
      if (resp_v_o)
      begin
        if (!seen)
        begin
          seen       = 1'b1;
          first_resp = cycle_count;
          held       = resp_data_o;
        end
        else
          check_value("held response data", held, resp_data_o);
        done = resp_ready_i;
      end
      else if (seen)
        check_value("response valid held", 1, 32'(resp_v_o));
    end
    if (cur_we)
      check_value("store response data", '0, held);
    else
      check_value("load data", backing[cur_addr[15:2]], held);
    if (!cur_we && hit)
      check_value("load hit latency", 2, first_resp - accept_cycle);
    check_value("fill requests", (!cur_we && !hit) ? 1 : 0, fill_seen);
    check_value("write-through requests", cur_we ? 1 : 0, wt_seen);
    req_count++;
    if (cur_we)
      store_count++;
    if (hit)
    begin
      model_hits++;
      model_lru[idx] = ~hit_way;
    end
    else
    begin
      model_misses++;
      if (!cur_we)
      begin
        victim = !model_valid[idx][0] ? 1'b0 :
                 !model_valid[idx][1] ? 1'b1 : model_lru[idx];
        model_tag[idx][victim]   = cur_addr[15:8];
        model_valid[idx][victim] = 1'b1;
        model_lru[idx]           = ~victim;
      end
    end
  endtask

  initial
  begin
    seed         = 32'hcd1c;
    cycle_count  = 0;
    req_count    = 0;
    store_count  = 0;
    model_hits   = 0;
    model_misses = 0;
    fill_seen    = 0;
    wt_seen      = 0;
    fill_delay   = 0;
    fill_pending = 1'b0;
    fill_base    = '0;
    cur_we       = 1'b0;
    cur_addr     = '0;
    cur_wdata    = '0;
    reset_i         = 1'b1;
    req_v_i         = 1'b0;
    req_we_i        = 1'b0;
    req_addr_i      = '0;
    req_wdata_i     = '0;
    resp_ready_i    = 1'b0;
    mem_req_ready_i = 1'b0;
    mem_resp_v_i    = 1'b0;
    mem_resp_data_i = '0;
    for (int a = 0; a < MEM_WORDS; a++)
      backing[a] = {~a[7:0], 2'b01, a[13:0], a[7:0]};
    for (int s = 0; s < `DCACHE_SETS; s++)
    begin
      model_valid[s] = 2'b00;
      model_lru[s]   = 1'b0;
    end
    tick();
    tick();
    reset_i <= 1'b0;
    tick();
    check_value("ready after reset", 1, 32'(req_ready_o));
    check_value("response valid after reset", 0, 32'(resp_v_o));
    check_value("memory request after reset", 0, 32'(mem_req_v_o));
    check_stats();
    for (int n = 0; n < NUM_REQS; n++)
    begin
      run_request();
      if (({$random(seed)} % 8) == 0)
        check_stats();
    end
    check_stats();
    $display("Simulation passed");
    $finish;
  end

endmodule

// File: verilog/dcache_ctrl_fsm.sv
`timescale 1ns/1ps
`include "dcache_settings.svh"

module dcache_ctrl_fsm (
  input  logic                          clk_i,
  input  logic                          reset_i,
  input  logic                          req_v_i,
  output logic                          req_ready_o,
  input  logic                          req_we_i,
  input  dcache_pkg::paddr_u            req_addr_i,
  input  logic [`DCACHE_WORD_W-1:0]     req_wdata_i,
  output logic                          resp_v_o,
  output logic [`DCACHE_WORD_W-1:0]     resp_data_o,
  input  logic                          resp_ready_i,
  output logic                          mem_req_v_o,
  output logic                          mem_req_we_o,
  output logic [`DCACHE_ADDR_W-1:0]     mem_req_addr_o,
  output logic [`DCACHE_WORD_W-1:0]     mem_req_data_o,
  input  logic                          mem_req_ready_i,
  input  logic                          mem_resp_v_i,
  input  logic [`DCACHE_BLOCK_W-1:0]    mem_resp_data_i,
  output logic                          hit_event_o,
  output logic                          miss_event_o,
  output logic                          wt_event_o,
  tag_mem_if.ctrl                       tag_o,
  data_mem_if.ctrl                      data_o
);
  import dcache_pkg::*;

  typedef enum logic [2:0] {
    IDLE,
    LOOKUP,
    VERIFY,
    MISS_REQ,
    FILL,
    WT_REQ,
    RESP
  } state_e;

  state_e                      state_r;
  state_e                      state_n;
  logic                        req_we_r;
  paddr_u                      req_addr_r;
  logic [`DCACHE_WORD_W-1:0]   req_wdata_r;
  logic                        way_r;
  logic                        store_hit_r;
  logic [`DCACHE_WORD_W-1:0]   resp_data_r;
  logic [`DCACHE_WORD_W-1:0]   fill_word;
  mem_req_type_e               mem_type;
  paddr_u                      fill_addr;

  // Requested word out of the returning block
  assign fill_word = mem_resp_data_i[req_addr_r.f.word_sel*`DCACHE_WORD_W +: `DCACHE_WORD_W];

  always_comb
  begin
    fill_addr = req_addr_r;
    fill_addr.f.word_sel = '0;
    fill_addr.f.byte_off = '0;
  end

  assign tag_o.index      = req_addr_r.f.index;
  assign tag_o.tag        = req_addr_r.f.tag;
  assign data_o.index     = req_addr_r.f.index;
  assign data_o.word_sel  = req_addr_r.f.word_sel;
  assign data_o.fill_data = mem_resp_data_i;
  assign data_o.wdata     = req_wdata_r;
  assign data_o.way_id    = way_r;
  assign data_o.sel_way   = tag_o.hit_way;

  assign mem_req_we_o   = (mem_type == e_mem_write_through);
  assign mem_req_addr_o = mem_req_we_o ? req_addr_r.raw : fill_addr.raw;
  assign mem_req_data_o = mem_req_we_o ? req_wdata_r : '0;

  always_comb
  begin
    state_n       = state_r;
    req_ready_o   = 1'b0;
    resp_v_o      = 1'b0;
    resp_data_o   = resp_data_r;
    mem_req_v_o   = 1'b0;
    mem_type      = e_mem_fill_load;
    hit_event_o   = 1'b0;
    miss_event_o  = 1'b0;
    wt_event_o    = 1'b0;
    tag_o.v       = 1'b0;
    tag_o.opcode  = e_tag_read;
    tag_o.way_id  = way_r;
    data_o.v      = 1'b0;
    data_o.opcode = e_data_read;

    case (state_r)
      IDLE:
      begin
        req_ready_o = 1'b1;
        if (req_v_i)
          state_n = LOOKUP;
      end
      LOOKUP:
      begin
        tag_o.v  = 1'b1;
        data_o.v = 1'b1;
        state_n  = VERIFY;
      end
      VERIFY:
      begin
        hit_event_o  = tag_o.hit;
        miss_event_o = ~tag_o.hit;
        if (req_we_r)
          state_n = WT_REQ;
        else if (tag_o.hit)
        begin
          // Load hit answers straight from the read register
          resp_v_o     = 1'b1;
          resp_data_o  = data_o.rdata;
          tag_o.v      = 1'b1;
          tag_o.opcode = e_tag_touch;
          tag_o.way_id = tag_o.hit_way;
          state_n      = resp_ready_i ? IDLE : RESP;
        end
        else
          state_n = MISS_REQ;
      end
      MISS_REQ:
      begin
        mem_req_v_o = 1'b1;
        if (mem_req_ready_i)
          state_n = FILL;
      end
      FILL:
      begin
        if (mem_resp_v_i)
        begin
          tag_o.v       = 1'b1;
          tag_o.opcode  = e_tag_set_tag;
          data_o.v      = 1'b1;
          data_o.opcode = e_data_fill;
          state_n       = RESP;
        end
      end
      WT_REQ:
      begin
        mem_req_v_o = 1'b1;
        mem_type    = e_mem_write_through;
        if (mem_req_ready_i)
        begin
          wt_event_o = 1'b1;
          if (store_hit_r)
          begin
            tag_o.v       = 1'b1;
            tag_o.opcode  = e_tag_touch;
            data_o.v      = 1'b1;
            data_o.opcode = e_data_write_word;
          end
          state_n = RESP;
        end
      end
      RESP:
      begin
        resp_v_o = 1'b1;
        if (resp_ready_i)
          state_n = IDLE;
      end
      default:
        state_n = IDLE;
    endcase
  end

  always_ff @(posedge clk_i)
  begin
    if (reset_i)
      state_r <= IDLE;
    else
      state_r <= state_n;
  end

  always_ff @(posedge clk_i)
  begin
    case (state_r)
      IDLE:
      begin
        if (req_v_i)
        begin
          req_we_r    <= req_we_i;
          req_addr_r  <= req_addr_i;
          req_wdata_r <= req_wdata_i;
        end
      end
      VERIFY:
      begin
        // Hit way for stores, victim for fills
        way_r       <= tag_o.hit ? tag_o.hit_way : tag_o.victim_way;
        store_hit_r <= tag_o.hit;
        resp_data_r <= data_o.rdata;
      end
      FILL:
      begin
        if (mem_resp_v_i)
          resp_data_r <= fill_word;
      end
      WT_REQ:
      begin
        if (mem_req_ready_i)
          resp_data_r <= '0;
      end
      default:
      begin
      end
    endcase
  end

endmodule

// File: verilog/dcache_data_mem.sv
`timescale 1ns/1ps
`include "dcache_settings.svh"

module dcache_data_mem (
  input  logic    clk_i,
  data_mem_if.mem data_i
);
  import dcache_pkg::*;

  logic [`DCACHE_BLOCK_W-1:0] blocks_r [`DCACHE_SETS][`DCACHE_WAYS];
  // Both ways of the last set read
  logic [`DCACHE_BLOCK_W-1:0] read_r [`DCACHE_WAYS];
  logic [`DCACHE_BLOCK_W-1:0] sel_block;

  always_ff @(posedge clk_i)
  begin
    if (data_i.v)
    begin
      case (data_i.opcode)
        e_data_read:
        begin
          for (int w = 0; w < `DCACHE_WAYS; w++)
            read_r[w] <= blocks_r[data_i.index][w];
        end
        e_data_fill:
          blocks_r[data_i.index][data_i.way_id] <= data_i.fill_data;
        e_data_write_word:
          blocks_r[data_i.index][data_i.way_id][data_i.word_sel*`DCACHE_WORD_W +: `DCACHE_WORD_W]
            <= data_i.wdata;
        default:
        begin
        end
      endcase
    end
  end

  assign sel_block    = read_r[data_i.sel_way];
  assign data_i.rdata = sel_block[data_i.word_sel*`DCACHE_WORD_W +: `DCACHE_WORD_W];

endmodule

// File: verilog/dcache_event_counter.sv
`timescale 1ns/1ps
`include "dcache_settings.svh"

module dcache_event_counter (
  input  logic                      clk_i,
  input  logic                      reset_i,
  input  logic                      hit_event_i,
  input  logic                      miss_event_i,
  input  logic                      wt_event_i,
  tag_mem_if.mon                    tag_i,
  data_mem_if.mon                   data_i,
  output logic [`DCACHE_STAT_W-1:0] tag_read_count_o,
  output logic [`DCACHE_STAT_W-1:0] data_read_count_o,
  output logic [`DCACHE_STAT_W-1:0] hit_count_o,
  output logic [`DCACHE_STAT_W-1:0] miss_count_o,
  output logic [`DCACHE_STAT_W-1:0] wt_count_o
);
  import dcache_pkg::*;

  localparam int NUM_CNT = 5;

  logic [NUM_CNT-1:0]       inc;
  logic [`DCACHE_STAT_W-1:0] count_r [NUM_CNT];

  // Valid read packets only, writes are not counted
  assign inc[0] = tag_i.v && (tag_i.opcode == e_tag_read);
  assign inc[1] = data_i.v && (data_i.opcode == e_data_read);
  assign inc[2] = hit_event_i;
  assign inc[3] = miss_event_i;
  assign inc[4] = wt_event_i;

  always_ff @(posedge clk_i)
  begin
    if (reset_i)
    begin
      for (int i = 0; i < NUM_CNT; i++)
        count_r[i] <= '0;
    end
    else
    begin
      for (int i = 0; i < NUM_CNT; i++)
      begin
        // Saturate at all ones
        if (inc[i] && !(&count_r[i]))
          count_r[i] <= count_r[i] + 1'b1;
      end
    end
  end

  assign tag_read_count_o  = count_r[0];
  assign data_read_count_o = count_r[1];
  assign hit_count_o       = count_r[2];
  assign miss_count_o      = count_r[3];
  assign wt_count_o        = count_r[4];

endmodule

// File: verilog/dcache_mem_if.sv
`timescale 1ns/1ps
`include "dcache_settings.svh"

interface tag_mem_if;
  import dcache_pkg::*;

  logic                     v;
  tag_op_e                  opcode;
  logic [`DCACHE_INDEX_W-1:0] index;
  logic                     way_id;
  logic [`DCACHE_TAG_W-1:0] tag;

  // Lookup results, one cycle after a read
  logic                     hit;
  logic                     hit_way;
  logic                     victim_way;

  modport ctrl (output v, opcode, index, way_id, tag, input hit, hit_way, victim_way);
  modport mem (input v, opcode, index, way_id, tag, output hit, hit_way, victim_way);
  modport mon (input v, opcode);
endinterface

interface data_mem_if;
  import dcache_pkg::*;

  logic                         v;
  data_op_e                     opcode;
  logic [`DCACHE_INDEX_W-1:0]   index;
  logic                         way_id;
  logic [`DCACHE_WORD_SEL_W-1:0] word_sel;
  logic [`DCACHE_BLOCK_W-1:0]   fill_data;
  logic [`DCACHE_WORD_W-1:0]    wdata;
  logic                         sel_way;
  logic [`DCACHE_WORD_W-1:0]    rdata;

  modport ctrl (output v, opcode, index, way_id, word_sel, fill_data, wdata, sel_way,
                input rdata);
  modport mem (input v, opcode, index, way_id, word_sel, fill_data, wdata, sel_way,
               output rdata);
  modport mon (input v, opcode);
endinterface

// File: verilog/dcache_pkg.sv
`include "dcache_settings.svh"

package dcache_pkg;

  // Tag memory operations
  typedef enum logic [1:0] {
    e_tag_read,
    e_tag_set_tag,
    // Updates the LRU bit only
    e_tag_touch
  } tag_op_e;

  // Data memory operations
  typedef enum logic [1:0] {
    e_data_read,
    e_data_fill,
    e_data_write_word
  } data_op_e;

  // Requests toward the next level
  typedef enum logic {
    e_mem_fill_load,
    e_mem_write_through
  } mem_req_type_e;

  // One address word, seen whole on the memory port
  // and split into fields for lookup
  typedef union packed {
    logic [`DCACHE_ADDR_W-1:0] raw;
    struct packed {
      logic [`DCACHE_TAG_W-1:0]      tag;
      logic [`DCACHE_INDEX_W-1:0]    index;
      logic [`DCACHE_WORD_SEL_W-1:0] word_sel;
      logic [`DCACHE_ADDR_W-`DCACHE_TAG_W-`DCACHE_INDEX_W-`DCACHE_WORD_SEL_W-1:0] byte_off;
    } f;
  } paddr_u;

endpackage

// File: verilog/dcache_settings.svh
`ifndef DCACHE_SETTINGS_SVH
`define DCACHE_SETTINGS_SVH

// Address split: tag | index | word | byte
`define DCACHE_ADDR_W 16
`define DCACHE_TAG_W 8
`define DCACHE_INDEX_W 4
`define DCACHE_WORD_SEL_W 2

`define DCACHE_SETS 16
`define DCACHE_WAYS 2

`define DCACHE_WORD_W 32
// Four words per block
`define DCACHE_BLOCK_W 128

`define DCACHE_STAT_W 32

`endif

// File: verilog/dcache_tag_mem.sv
`timescale 1ns/1ps
`include "dcache_settings.svh"

module dcache_tag_mem (
  input  logic   clk_i,
  input  logic   reset_i,
  tag_mem_if.mem tag_i
);
  import dcache_pkg::*;

  logic [`DCACHE_TAG_W-1:0]   tags_r [`DCACHE_SETS][`DCACHE_WAYS];
  logic [`DCACHE_WAYS-1:0]    valid_r [`DCACHE_SETS];
  // Per set, points at the least recently used way
  logic [`DCACHE_SETS-1:0]    lru_r;
  logic [`DCACHE_TAG_W-1:0]   lookup_tag_r;
  logic [`DCACHE_INDEX_W-1:0] lookup_index_r;
  logic [`DCACHE_WAYS-1:0]    match;
  logic [`DCACHE_WAYS-1:0]    set_valid;

  always_ff @(posedge clk_i)
  begin
    if (tag_i.v && tag_i.opcode == e_tag_read)
    begin
      lookup_tag_r   <= tag_i.tag;
      lookup_index_r <= tag_i.index;
    end
    if (tag_i.v && tag_i.opcode == e_tag_set_tag)
      tags_r[tag_i.index][tag_i.way_id] <= tag_i.tag;
  end

  always_ff @(posedge clk_i)
  begin
    if (reset_i)
    begin
      for (int s = 0; s < `DCACHE_SETS; s++)
        valid_r[s] <= '0;
      lru_r <= '0;
    end
    else if (tag_i.v)
    begin
      case (tag_i.opcode)
        e_tag_set_tag:
        begin
          valid_r[tag_i.index][tag_i.way_id] <= 1'b1;
          lru_r[tag_i.index] <= ~tag_i.way_id;
        end
        e_tag_touch:
          lru_r[tag_i.index] <= ~tag_i.way_id;
        default:
        begin
        end
      endcase
    end
  end

  assign set_valid = valid_r[lookup_index_r];

  always_comb
  begin
    for (int w = 0; w < `DCACHE_WAYS; w++)
      match[w] = set_valid[w] && (tags_r[lookup_index_r][w] == lookup_tag_r);
  end

  assign tag_i.hit     = |match;
  assign tag_i.hit_way = match[1];

  // Empty way first, else LRU
  assign tag_i.victim_way = !set_valid[0] ? 1'b0 :
                            !set_valid[1] ? 1'b1 : lru_r[lookup_index_r];

endmodule

// File: verilog/dcache_top.sv
`timescale 1ns/1ps
`include "dcache_settings.svh"

module dcache_top (
  input  logic                       clk_i,
  input  logic                       reset_i,
  input  logic                       req_v_i,
  output logic                       req_ready_o,
  input  logic                       req_we_i,
  input  logic [`DCACHE_ADDR_W-1:0]  req_addr_i,
  input  logic [`DCACHE_WORD_W-1:0]  req_wdata_i,
  output logic                       resp_v_o,
  output logic [`DCACHE_WORD_W-1:0]  resp_data_o,
  input  logic                       resp_ready_i,
  output logic                       mem_req_v_o,
  output logic                       mem_req_we_o,
  output logic [`DCACHE_ADDR_W-1:0]  mem_req_addr_o,
  output logic [`DCACHE_WORD_W-1:0]  mem_req_data_o,
  input  logic                       mem_req_ready_i,
  input  logic                       mem_resp_v_i,
  input  logic [`DCACHE_BLOCK_W-1:0] mem_resp_data_i,
  output logic [`DCACHE_STAT_W-1:0]  stat_tag_read_count_o,
  output logic [`DCACHE_STAT_W-1:0]  stat_data_read_count_o,
  output logic [`DCACHE_STAT_W-1:0]  stat_hit_count_o,
  output logic [`DCACHE_STAT_W-1:0]  stat_miss_count_o,
  output logic [`DCACHE_STAT_W-1:0]  stat_wt_count_o
);

  logic hit_event;
  logic miss_event;
  logic wt_event;

  tag_mem_if  tag_bus ();
  data_mem_if data_bus ();

  dcache_ctrl_fsm ctrl (
    .clk_i           (clk_i),
    .reset_i         (reset_i),
    .req_v_i         (req_v_i),
    .req_ready_o     (req_ready_o),
    .req_we_i        (req_we_i),
    .req_addr_i      (req_addr_i),
    .req_wdata_i     (req_wdata_i),
    .resp_v_o        (resp_v_o),
    .resp_data_o     (resp_data_o),
    .resp_ready_i    (resp_ready_i),
    .mem_req_v_o     (mem_req_v_o),
    .mem_req_we_o    (mem_req_we_o),
    .mem_req_addr_o  (mem_req_addr_o),
    .mem_req_data_o  (mem_req_data_o),
    .mem_req_ready_i (mem_req_ready_i),
    .mem_resp_v_i    (mem_resp_v_i),
    .mem_resp_data_i (mem_resp_data_i),
    .hit_event_o     (hit_event),
    .miss_event_o    (miss_event),
    .wt_event_o      (wt_event),
    .tag_o           (tag_bus.ctrl),
    .data_o          (data_bus.ctrl)
  );

  dcache_tag_mem tags (
    .clk_i   (clk_i),
    .reset_i (reset_i),
    .tag_i   (tag_bus.mem)
  );

  dcache_data_mem data (
    .clk_i  (clk_i),
    .data_i (data_bus.mem)
  );

  dcache_event_counter stats (
    .clk_i             (clk_i),
    .reset_i           (reset_i),
    .hit_event_i       (hit_event),
    .miss_event_i      (miss_event),
    .wt_event_i        (wt_event),
    .tag_i             (tag_bus.mon),
    .data_i            (data_bus.mon),
    .tag_read_count_o  (stat_tag_read_count_o),
    .data_read_count_o (stat_data_read_count_o),
    .hit_count_o       (stat_hit_count_o),
    .miss_count_o      (stat_miss_count_o),
    .wt_count_o        (stat_wt_count_o)
  );

endmodule
